// File: Bender.yml
package:
  name: tpu_systolic

sources:
  - src/tpu_pkg.sv
  - src/pe.sv
  - src/pe_array.sv
  - src/operand_skew.sv
  - src/result_buffer.sv
  - src/tpu_ctrl.sv
  - src/tpu_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_tpu.sv

// File: dv/tb_tpu_cases.svh
// Job shapes and traffic modes, applied in order without idle gaps
localparam int NUM_CASES = 8;

typedef struct {
    string name;
    int    m;
    int    k;
    bit    in_gaps;
    bit    out_stalls;
} case_t;

case_t cases [NUM_CASES] = '{
    '{"full_5x5",         5, 5, 1'b0, 1'b0},
    '{"m3_k2",            3, 2, 1'b0, 1'b0},
    '{"m1_k1",            1, 1, 1'b0, 1'b0},
    '{"m5_k1",            5, 1, 1'b0, 1'b0},
    '{"m2_k5",            2, 5, 1'b0, 1'b0},
    '{"full_gaps_stalls", 5, 5, 1'b1, 1'b1},
    '{"m4_k3_stalls",     4, 3, 1'b0, 1'b1},
    '{"m1_k5_gaps",       1, 5, 1'b1, 1'b1}
};

// File: dv/tb_tpu.sv
`timescale 1ns/100ps

module tb_tpu import tpu_pkg::*; ();

    `include "tb_tpu_cases.svh"

    localparam int CYCLE_LIMIT = 300 * NUM_CASES + 8;

    logic  clk = 1'b0;
    logic  rst;
    logic  start_i;
    dim_t  m_i;
    dim_t  k_i;
    logic  busy_o;
    logic  in_valid_i;
    logic  in_ready_o;
    word_t a_col_i;
    word_t b_row_i;
    logic  out_valid_o;
    logic  out_ready_i;
    word_t out_row_o;
    logic  out_last_o;

    int    seed;
    int    cycles = 0;
    string cur_name;
    elem_t a_m [ARRAY_DIM][ARRAY_DIM];
    elem_t b_m [ARRAY_DIM][ARRAY_DIM];

    tpu_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .m_i         (m_i),
        .k_i         (k_i),
        .busy_o      (busy_o),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .a_col_i     (a_col_i),
        .b_row_i     (b_row_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_row_o   (out_row_o),
        .out_last_o  (out_last_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the DUT did not finish the jobs within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $fatal(1);
        end
    end

    task automatic check_val(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAIL %s: %s expected %h actual %h", cur_name, what, exp, act);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // High most of the time when traffic is irregular
    function automatic logic draw_enable(input bit irregular);
        return irregular ? (($random(seed) & 3) != 0) : 1'b1;
    endfunction

    // Column r of A and row r of B, element 0 in the top byte
    task automatic drive_beat(input int r, input bit gaps);
        for (int i = 0; i < ARRAY_DIM; i++) begin
            a_col_i[(ARRAY_DIM-1-i)*ELEM_W +: ELEM_W] = a_m[i][r];
            b_row_i[(ARRAY_DIM-1-i)*ELEM_W +: ELEM_W] = b_m[r][i];
        end
        in_valid_i = draw_enable(gaps);
    endtask

    function automatic word_t expected_row(input int i, input int k);
        word_t row;
        elem_t acc;
        for (int c = 0; c < ARRAY_DIM; c++) begin
            acc = '0;
            for (int r = 0; r < k; r++) begin
                acc = acc + a_m[i][r] * b_m[r][c];
            end
            row[(ARRAY_DIM-1-c)*ELEM_W +: ELEM_W] = acc;
        end
        return row;
    endfunction

    task automatic run_case(input int n);
        int m;
        int k;
        int beat;
        int row;
        int lat;
        m = cases[n].m;
        k = cases[n].k;
        cur_name = cases[n].name;
        // Elements outside the job shape are random as well
        for (int i = 0; i < ARRAY_DIM; i++) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                a_m[i][j] = $random(seed);
                b_m[i][j] = $random(seed);
            end
        end
        @(posedge clk);
        #2;
        start_i = 1'b1;
        m_i = dim_t'(m);
        k_i = dim_t'(k);
        @(negedge clk);
        check_val("busy_o before start", 1'b0, busy_o);
        check_val("in_ready_o before start", 1'b0, in_ready_o);
        @(posedge clk);
        #2;
        start_i = 1'b0;
        drive_beat(0, cases[n].in_gaps);
        @(negedge clk);
        check_val("busy_o after start", 1'b1, busy_o);
        beat = 0;
        while (beat < k) begin
            check_val("in_ready_o during load", 1'b1, in_ready_o);
            @(posedge clk);
            if (in_valid_i) begin
                beat++;
            end
            #2;
            if (beat < k) begin
                drive_beat(beat, cases[n].in_gaps);
            end else begin
                in_valid_i = 1'b0;
            end
            out_ready_i = draw_enable(cases[n].out_stalls);
            @(negedge clk);
        end
        check_val("in_ready_o after k beats", 1'b0, in_ready_o);
        lat = 0;
        while (!out_valid_o) begin
            lat++;
            @(posedge clk);
            #2 out_ready_i = draw_enable(cases[n].out_stalls);
            @(negedge clk);
        end
        check_val("cycles from last beat to out_valid_o", EXE_CYCLES, lat);
        row = 0;
        while (row < m) begin
            check_val($sformatf("out_valid_o on row %0d", row), 1'b1, out_valid_o);
            check_val($sformatf("row %0d", row), expected_row(row, k), out_row_o);
            check_val($sformatf("out_last_o on row %0d", row), row == m - 1, out_last_o);
            @(posedge clk);
            if (out_ready_i) begin
                row++;
            end
            #2 out_ready_i = draw_enable(cases[n].out_stalls);
            @(negedge clk);
        end
        check_val("out_valid_o after last row", 1'b0, out_valid_o);
        check_val("busy_o after last row", 1'b0, busy_o);
    endtask

    initial begin
        seed        = 32'hb27b8477;
        cur_name    = "reset";
        rst         = 1'b1;
        start_i     = 1'b0;
        m_i         = '0;
        k_i         = '0;
        in_valid_i  = 1'b0;
        a_col_i     = '0;
        b_row_i     = '0;
        out_ready_i = 1'b0;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        check_val("in_ready_o", 1'b0, in_ready_o);
        check_val("out_valid_o", 1'b0, out_valid_o);
        check_val("out_last_o", 1'b0, out_last_o);
        check_val("busy_o", 1'b0, busy_o);
        for (int n = 0; n < NUM_CASES; n++) begin
            run_case(n);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+dv
src/tpu_pkg.sv
src/pe.sv
src/pe_array.sv
src/operand_skew.sv
src/result_buffer.sv
src/tpu_ctrl.sv
src/tpu_top.sv
dv/tb_tpu.sv

// File: src/operand_skew.sv
`timescale 1ns/100ps

module operand_skew import tpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  load_en_i,
    input  dim_t  load_row_i,
    input  word_t a_col_i,
    input  logic  exe_en_i,
    output word_t left_col_o
);

    // Slot 0 is the head presented to the array
    elem_t skew_q [ARRAY_DIM][2*ARRAY_DIM];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < ARRAY_DIM; r++) begin
                for (int s = 0; s < 2*ARRAY_DIM; s++) begin
                    skew_q[r][s] <= '0;
                end
            end
        end else if (load_en_i) begin
            for (int r = 0; r < ARRAY_DIM; r++) begin
                if (load_row_i == dim_t'(r)) begin
                    for (int s = 0; s < 2*ARRAY_DIM; s++) begin
                        skew_q[r][s] <= '0;
                    end
                    // r leading zeros give the diagonal skew
                    for (int i = 0; i < ARRAY_DIM; i++) begin
                        skew_q[r][r+i] <= a_col_i[(ARRAY_DIM-1-i)*ELEM_W +: ELEM_W];
                    end
                end else if (load_row_i == '0) begin
                    for (int s = 0; s < 2*ARRAY_DIM; s++) begin
                        skew_q[r][s] <= '0;
                    end
                end
            end
        end else if (exe_en_i) begin
            for (int r = 0; r < ARRAY_DIM; r++) begin
                for (int s = 0; s < 2*ARRAY_DIM-1; s++) begin
                    skew_q[r][s] <= skew_q[r][s+1];
                end
                skew_q[r][2*ARRAY_DIM-1] <= '0;
            end
        end
    end

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_head
        assign left_col_o[(ARRAY_DIM-1-r)*ELEM_W +: ELEM_W] = skew_q[r][0];
    end

endmodule

// File: src/pe.sv
`timescale 1ns/100ps

module pe import tpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  weight_en_i,
    input  elem_t weight_i,
    input  logic  exe_en_i,
    input  elem_t left_i,
    input  elem_t up_i,
    output elem_t right_o,
    output elem_t down_o
);

    elem_t weight_q;
    elem_t right_q;
    elem_t down_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weight_q <= '0;
            right_q  <= '0;
            down_q   <= '0;
        end else begin
            if (weight_en_i) begin
                weight_q <= weight_i;
            end
            // Operand moves right, partial sum moves down
            if (exe_en_i) begin
                right_q <= left_i;
                down_q  <= up_i + left_i * weight_q;
            end
        end
    end

    assign right_o = right_q;
    assign down_o  = down_q;

endmodule

// File: src/pe_array.sv
`timescale 1ns/100ps

module pe_array import tpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  load_en_i,
    input  dim_t  load_row_i,
    input  word_t weight_row_i,
    input  logic  exe_en_i,
    input  word_t left_col_i,
    output word_t bottom_o
);

    // Rightward operand links, column 0 fed from the left edge
    elem_t h_w [ARRAY_DIM][ARRAY_DIM+1];
    // Downward sum links, row 0 fed with zero
    elem_t v_w [ARRAY_DIM+1][ARRAY_DIM];

    logic  row_en [ARRAY_DIM];
    word_t row_w  [ARRAY_DIM];

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        // First beat of a job also clears the rows above k
        assign row_en[r] = load_en_i && (load_row_i == dim_t'(r) || load_row_i == '0);
        assign row_w[r]  = (load_row_i == dim_t'(r)) ? weight_row_i : '0;

        assign h_w[r][0] = left_col_i[(ARRAY_DIM-1-r)*ELEM_W +: ELEM_W];

        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            pe u_pe (
                .clk         (clk),
                .rst         (rst),
                .weight_en_i (row_en[r]),
                .weight_i    (row_w[r][(ARRAY_DIM-1-c)*ELEM_W +: ELEM_W]),
                .exe_en_i    (exe_en_i),
                .left_i      (h_w[r][c]),
                .up_i        (v_w[r][c]),
                .right_o     (h_w[r][c+1]),
                .down_o      (v_w[r+1][c])
            );
        end
    end

    for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_edge
        assign v_w[0][c] = '0;
        assign bottom_o[(ARRAY_DIM-1-c)*ELEM_W +: ELEM_W] = v_w[ARRAY_DIM][c];
    end

endmodule

// File: src/result_buffer.sv
`timescale 1ns/100ps

module result_buffer import tpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   exe_en_i,
    input  cycle_t exe_cnt_i,
    input  word_t  bottom_i,
    input  dim_t   rd_row_i,
    output word_t  row_o
);

    word_t rows_q [ARRAY_DIM];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ARRAY_DIM; i++) begin
                rows_q[i] <= '0;
            end
        end else if (exe_en_i) begin
            // Column c lags by c cycles, so each element has its own slot
            for (int i = 0; i < ARRAY_DIM; i++) begin
                for (int c = 0; c < ARRAY_DIM; c++) begin
                    if (exe_cnt_i == cycle_t'(i + c + PIPE_OFFSET)) begin
                        rows_q[i][(ARRAY_DIM-1-c)*ELEM_W +: ELEM_W] <=
                            bottom_i[(ARRAY_DIM-1-c)*ELEM_W +: ELEM_W];
                    end
                end
            end
        end
    end

    assign row_o = rows_q[rd_row_i];

endmodule

// File: src/tpu_ctrl.sv
`timescale 1ns/100ps

module tpu_ctrl import tpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start_i,
    input  dim_t   m_i,
    input  dim_t   k_i,
    output logic   busy_o,
    input  logic   in_valid_i,
    output logic   in_ready_o,
    input  logic   out_ready_i,
    output logic   out_valid_o,
    output logic   out_last_o,
    output logic   load_en_o,
    output dim_t   load_row_o,
    output logic   exe_en_o,
    output cycle_t exe_cnt_o,
    output dim_t   rd_row_o
);

    ctrl_state_t state_q;
    dim_t        m_q;
    dim_t        k_q;
    dim_t        beat_q;
    cycle_t      exe_q;
    dim_t        orow_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            m_q     <= '0;
            k_q     <= '0;
            beat_q  <= '0;
            exe_q   <= '0;
            orow_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        m_q     <= m_i;
                        k_q     <= k_i;
                        beat_q  <= '0;
                        state_q <= LOAD;
                    end
                end
                LOAD: begin
                    if (in_valid_i) begin
                        beat_q <= beat_q + 3'd1;
                        if (beat_q == k_q - 3'd1) begin
                            exe_q   <= '0;
                            state_q <= EXE;
                        end
                    end
                end
                EXE: begin
                    if (exe_q == cycle_t'(EXE_CYCLES - 1)) begin
                        orow_q  <= '0;
                        state_q <= OUTPUT;
                    end else begin
                        exe_q <= exe_q + 4'd1;
                    end
                end
                OUTPUT: begin
                    if (out_ready_i) begin
                        if (out_last_o) begin
                            state_q <= IDLE;
                        end else begin
                            orow_q <= orow_q + 3'd1;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign busy_o      = (state_q != IDLE);
    assign in_ready_o  = (state_q == LOAD);
    assign load_en_o   = in_ready_o && in_valid_i;
    assign load_row_o  = beat_q;
    assign exe_en_o    = (state_q == EXE);
    assign exe_cnt_o   = exe_q;
    assign out_valid_o = (state_q == OUTPUT);
    assign out_last_o  = out_valid_o && (orow_q == m_q - 3'd1);
    assign rd_row_o    = orow_q;

    a_dims_legal: assert property (@(posedge clk) disable iff (rst)
        (state_q == IDLE && start_i) |->
            (m_i inside {[1:ARRAY_DIM]}) && (k_i inside {[1:ARRAY_DIM]}));

    // Last row of C must reach the bottom edge before EXE ends
    a_exe_covers_rows: assert property (@(posedge clk) disable iff (rst)
        (state_q == EXE && exe_q == cycle_t'(EXE_CYCLES - 1)) |->
            (int'(m_q) + ARRAY_DIM - 2 + PIPE_OFFSET <= int'(exe_q)));

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(rd_row_o)));

    a_streams_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(in_ready_o && out_valid_o));

endmodule

// File: src/tpu_pkg.sv
package tpu_pkg;

    // Array geometry
    localparam int ARRAY_DIM = 5;
    localparam int ELEM_W    = 8;
    localparam int WORD_W    = ARRAY_DIM * ELEM_W;

    // Execute phase covers the longest skewed path plus operand flush
    localparam int EXE_CYCLES = 14;

    // Cycles from row 0 entry to the bottom edge of column 0
    localparam int PIPE_OFFSET = ARRAY_DIM;

    // One matrix element, wraps modulo 256
    typedef logic [ELEM_W-1:0] elem_t;

    // Five elements, element 0 in the top byte
    typedef logic [WORD_W-1:0] word_t;

    // Row count or inner dimension, 1 to 5
    typedef logic [2:0] dim_t;

    typedef logic [3:0] cycle_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        EXE,
        OUTPUT
    } ctrl_state_t;

endpackage

// File: src/tpu_top.sv
`timescale 1ns/100ps

module tpu_top import tpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start_i,
    input  dim_t  m_i,
    input  dim_t  k_i,
    output logic  busy_o,
    input  logic  in_valid_i,
    output logic  in_ready_o,
    input  word_t a_col_i,
    input  word_t b_row_i,
    output logic  out_valid_o,
    input  logic  out_ready_i,
    output word_t out_row_o,
    output logic  out_last_o
);

    logic   load_en;
    dim_t   load_row;
    logic   exe_en;
    cycle_t exe_cnt;
    dim_t   rd_row;
    word_t  left_col;
    word_t  bottom;

    tpu_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .m_i         (m_i),
        .k_i         (k_i),
        .busy_o      (busy_o),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .out_last_o  (out_last_o),
        .load_en_o   (load_en),
        .load_row_o  (load_row),
        .exe_en_o    (exe_en),
        .exe_cnt_o   (exe_cnt),
        .rd_row_o    (rd_row)
    );

    operand_skew u_skew (
        .clk        (clk),
        .rst        (rst),
        .load_en_i  (load_en),
        .load_row_i (load_row),
        .a_col_i    (a_col_i),
        .exe_en_i   (exe_en),
        .left_col_o (left_col)
    );

    // B row r becomes the stationary weights of array row r
    pe_array u_array (
        .clk          (clk),
        .rst          (rst),
        .load_en_i    (load_en),
        .load_row_i   (load_row),
        .weight_row_i (b_row_i),
        .exe_en_i     (exe_en),
        .left_col_i   (left_col),
        .bottom_o     (bottom)
    );

    result_buffer u_result (
        .clk       (clk),
        .rst       (rst),
        .exe_en_i  (exe_en),
        .exe_cnt_i (exe_cnt),
        .bottom_i  (bottom),
        .rd_row_i  (rd_row),
        .row_o     (out_row_o)
    );

endmodule
